// File: src.f
+incdir+include
logic/mem2rw_pkg.sv
logic/vaddr_map.sv
logic/delay_pipe.sv
logic/bank_sram.sv
logic/mem2rw_core.sv
logic/mem2rw_top.sv
tests/tb_clock.sv
tests/mem2rw_checker.sv
tests/tb_mem2rw.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the mem2rw testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wall -Wno-fatal \
  -f src.f --top-module tb_mem2rw -o tb_mem2rw_sim

./obj_dir/tb_mem2rw_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "NO ERRORS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: include/mem2rw_cases.svh
`ifndef MEM2RW_CASES_SVH
`define MEM2RW_CASES_SVH

// columns are test, then per port op, address, data, random-data flag
typedef struct packed {
  logic [7:0]         test;
  logic [1:0]         op0;
  logic [BITADDR-1:0] a0;
  logic [WIDTH-1:0]   d0;
  logic               r0;
  logic [1:0]         op1;
  logic [BITADDR-1:0] a1;
  logic [WIDTH-1:0]   d1;
  logic               r1;
} case_t;

localparam int NUM_CASES = 30;

function automatic case_t case_row(input int i);
  case (i)
    // ready still low, so these writes must be ignored
    0:  return '{1, OP_WR, 5, 32'h1111_1111, 0, OP_WR, 1005, 32'h2222_2222, 0};
    1:  return '{1, OP_WR, 5, 32'h3333_3333, 0, OP_WR, 1005, 32'h4444_4444, 0};
    2:  return '{1, OP_WR, 2500, 32'h5555_5555, 0, OP_WR, 7500, 32'h6666_6666, 0};
    3:  return '{2, OP_WR, 0, 32'h0000_a001, 0, OP_WR, 1999, 32'h0000_a002, 0};
    4:  return '{2, OP_WR, 2000, 32'h0, 1, OP_WR, 3999, 32'h0, 1};
    5:  return '{2, OP_WR, 4000, 32'h0000_a005, 0, OP_WR, 5999, 32'h0000_a006, 0};
    6:  return '{2, OP_WR, 6000, 32'h0, 1, OP_WR, 7999, 32'h0, 1};
    7:  return '{2, OP_WR, 999, 32'h0000_a009, 0, OP_WR, 1000, 32'h0000_a00a, 0};
    8:  return '{2, OP_RD, 0, 32'h0, 0, OP_RD, 1999, 32'h0, 0};
    9:  return '{2, OP_RD, 2000, 32'h0, 0, OP_RD, 3999, 32'h0, 0};
    10: return '{2, OP_RD, 4000, 32'h0, 0, OP_RD, 5999, 32'h0, 0};
    11: return '{2, OP_RD, 6000, 32'h0, 0, OP_RD, 7999, 32'h0, 0};
    12: return '{2, OP_RD, 999, 32'h0, 0, OP_RD, 1000, 32'h0, 0};
    13: return '{3, OP_RD, 7999, 32'h0, 0, OP_RD, 0, 32'h0, 0};
    14: return '{3, OP_RD, 5, 32'h0, 0, OP_RD, 1005, 32'h0, 0};
    15: return '{3, OP_RD, 2500, 32'h0, 0, OP_RD, 7500, 32'h0, 0};
    16: return '{3, OP_RD, 1000, 32'h0, 0, OP_RD, 999, 32'h0, 0};
    17: return '{4, OP_WR, 100, 32'h0000_b001, 0, OP_WR, 400, 32'h0000_c000, 0};
    18: return '{4, OP_RD, 100, 32'h0, 0, OP_WR, 100, 32'h0000_b003, 0};
    19: return '{4, OP_RD, 100, 32'h0, 0, OP_IDLE, 0, 32'h0, 0};
    20: return '{4, OP_WR, 200, 32'h0000_b004, 0, OP_WR, 200, 32'h0000_b005, 0};
    21: return '{4, OP_IDLE, 0, 32'h0, 0, OP_RD, 200, 32'h0, 0};
    22: return '{5, OP_WR, 300, 32'h0000_c001, 0, OP_WR, 300, 32'h0000_c002, 0};
    23: return '{5, OP_RD, 400, 32'h0, 0, OP_WR, 400, 32'h0000_c003, 0};
    24: return '{5, OP_WR, 400, 32'h0000_c004, 0, OP_IDLE, 0, 32'h0, 0};
    25: return '{5, OP_RD, 400, 32'h0, 0, OP_RD, 300, 32'h0, 0};
    26: return '{5, OP_RD, 200, 32'h0, 0, OP_RD, 100, 32'h0, 0};
    27: return '{6, OP_WR, 8000, 32'h0000_d001, 0, OP_WR, 8100, 32'h0000_d002, 0};
    28: return '{6, OP_RD, 0, 32'h0, 0, OP_RD, 100, 32'h0, 0};
    default: return '{6, OP_IDLE, 0, 32'h0, 0, OP_IDLE, 0, 32'h0, 0};
  endcase
endfunction

`endif

// File: tests/tb_mem2rw.sv
`timescale 1ns/1ps

module tb_mem2rw;
  import mem2rw_pkg::*;

  localparam int NUMADDR    = 8000;
  localparam int NUMVROW    = 1000;
  localparam int SRAM_DELAY = 2;

  localparam logic [1:0] OP_IDLE = 2'd0;
  localparam logic [1:0] OP_RD   = 2'd1;
  localparam logic [1:0] OP_WR   = 2'd2;

  `include "mem2rw_cases.svh"

  // table rows, then the read latency, then some slack
  localparam int LIMIT = NUM_CASES + SRAM_DELAY + 20;

  logic       clk;
  logic       rst;
  logic       ready;
  vport_req_t req [2];
  vport_rsp_t rsp [2];
  logic [7:0] cur_test;
  logic       done;
  int         n_checks;
  int         n_errors;
  int         cycles;

  tb_clock clk_gen (
    .clk (clk),
    .rst (rst)
  );

  mem2rw_top #(
    .NUMADDR    (NUMADDR),
    .NUMVROW    (NUMVROW),
    .SRAM_DELAY (SRAM_DELAY)
  ) dut0 (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .rsp   (rsp),
    .ready (ready)
  );

  mem2rw_checker #(
    .NUMADDR    (NUMADDR),
    .NUMVROW    (NUMVROW),
    .SRAM_DELAY (SRAM_DELAY)
  ) chk (
    .clk      (clk),
    .rst      (rst),
    .ready    (ready),
    .req      (req),
    .rsp      (rsp),
    .cur_test (cur_test),
    .done     (done),
    .n_checks (n_checks),
    .n_errors (n_errors)
  );

  task automatic drive_port(input int p, input logic [1:0] op, input logic [BITADDR-1:0] addr,
                            input logic [WIDTH-1:0] data, input logic rnd);
    req[p].read  = (op == OP_RD);
    req[p].write = (op == OP_WR);
    req[p].addr  = addr;
    req[p].data  = rnd ? $urandom : data;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial cycles = 0;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > LIMIT) begin
      $display("timeout after %0d cycles, responses still outstanding", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    case_t row;
    req[0]   = '0;
    req[1]   = '0;
    cur_test = '0;
    void'($urandom(32'hd1ed));
    for (int i = 0; i < NUM_CASES; i++) begin
      @(posedge clk);
      #1;
      row      = case_row(i);
      cur_test = row.test;
      drive_port(0, row.op0, row.a0, row.d0, row.r0);
      drive_port(1, row.op1, row.a1, row.d1, row.r1);
    end
    @(posedge clk);
    #1;
    req[0]   = '0;
    req[1]   = '0;
    cur_test = '0;  // no test open, lets the checker drain
    while (!done) @(posedge clk);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: tests/mem2rw_checker.sv
`timescale 1ns/1ps

module mem2rw_checker #(
  parameter int NUMADDR    = 8000,
  parameter int NUMVROW    = 1000,
  parameter int SRAM_DELAY = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   ready,
  input  mem2rw_pkg::vport_req_t req [2],
  input  mem2rw_pkg::vport_rsp_t rsp [2],
  input  logic [7:0]             cur_test,
  output logic                   done,
  output int                     n_checks,
  output int                     n_errors
);
  import mem2rw_pkg::*;

  localparam int DEPTH = 1 << BITADDR;

  typedef struct packed {
    logic [7:0]         test;
    logic               known;
    logic               fwrd;
    logic [WIDTH-1:0]   data;
    logic               stale_vld;  // a value was offered while ready was low
    logic [WIDTH-1:0]   stale;
    logic [BITPADR-1:0] padr;
    logic [31:0]        due;
  } exp_t;

  logic [WIDTH-1:0]   model     [DEPTH];
  logic               known     [DEPTH];
  logic               stale_vld [DEPTH];
  logic [WIDTH-1:0]   stale     [DEPTH];
  exp_t               pend      [2][$];
  logic               buf_vld;
  logic [BITADDR-1:0] buf_addr;
  logic [7:0]         open_test;
  logic               rst_last;  // reset level seen in the previous cycle
  int                 test_err  [256];
  int                 cyc;

  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      known[a]     = 1'b0;
      stale_vld[a] = 1'b0;
    end
    for (int t = 0; t < 256; t++) begin
      test_err[t] = 0;
    end
    buf_vld   = 1'b0;
    open_test = '0;
    rst_last  = 1'b1;
    cyc       = 0;
    done      = 1'b0;
    n_checks  = 0;
    n_errors  = 0;
  end

  function automatic logic [BITPADR-1:0] phys_addr(input logic [BITADDR-1:0] a);
    int bank;
    int row;
    bank = int'(a) / NUMVROW;
    row  = int'(a) % NUMVROW;
    return {BITVBNK'(bank), BITVROW'(row)};  // bank index above the row
  endfunction

  task automatic note_error(input logic [7:0] t);
    n_errors++;
    test_err[t]++;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response comparison
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_port(input int p);
    exp_t e;
    if (pend[p].size() > 0 && pend[p][0].due == cyc) begin
      e = pend[p].pop_front();
      n_checks++;
      if (!rsp[p].valid) begin
        $display("port %0d: read response missing in cycle %0d (test %0d)", p, cyc, e.test);
        note_error(e.test);
      end else begin
        if (rsp[p].padr !== e.padr) begin
          $display("FAILED rsp[%0d].padr got %h expected %h", p, rsp[p].padr, e.padr);
          note_error(e.test);
        end
        if (rsp[p].fwrd !== e.fwrd) begin
          $display("FAILED rsp[%0d].fwrd got %h expected %h", p, rsp[p].fwrd, e.fwrd);
          note_error(e.test);
        end
        if (e.known && rsp[p].data !== e.data) begin
          $display("FAILED rsp[%0d].data got %h expected %h", p, rsp[p].data, e.data);
          note_error(e.test);
        end
        if (!e.known && e.stale_vld && rsp[p].data === e.stale) begin
          $display("port %0d: read returned data that was written while ready was low", p);
          note_error(e.test);
        end
      end
    end else if (rsp[p].valid) begin
      $display("port %0d: unexpected read response in cycle %0d", p, cyc);
      note_error(open_test);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic record_cmds();
    logic [1:0] rd;
    logic [1:0] wr;
    logic       conflict;
    exp_t       e;
    for (int p = 0; p < 2; p++) begin
      rd[p] = ready & req[p].read;
      wr[p] = ready & req[p].write & (int'(req[p].addr) < NUMADDR);
    end
    conflict = (rd[0] | wr[0]) & (rd[1] | wr[1]) & (req[0].addr == req[1].addr);
    for (int p = 0; p < 2; p++) begin
      if (rd[p]) begin  // reads see the memory before this cycle's writes
        e.test      = cur_test;
        e.known     = known[req[p].addr];
        e.data      = model[req[p].addr];
        e.fwrd      = buf_vld && (req[p].addr == buf_addr);
        e.stale_vld = stale_vld[req[p].addr];
        e.stale     = stale[req[p].addr];
        e.padr      = phys_addr(req[p].addr);
        e.due       = cyc + SRAM_DELAY;
        pend[p].push_back(e);
      end
      if (!ready && req[p].write && int'(req[p].addr) < NUMADDR) begin
        stale_vld[req[p].addr] = 1'b1;
        stale[req[p].addr]     = req[p].data;
      end
    end
    for (int p = 0; p < 2; p++) begin
      if (wr[p]) begin  // port 1 goes last and wins a same-address pair
        model[req[p].addr] = req[p].data;
        known[req[p].addr] = 1'b1;
      end
    end
    if (conflict && (wr[0] || wr[1])) begin
      buf_vld  = 1'b1;
      buf_addr = req[0].addr;
    end else if (!conflict && buf_vld && ((wr[0] && req[0].addr == buf_addr) ||
                                          (wr[1] && req[1].addr == buf_addr))) begin
      buf_vld = 1'b0;
    end
  endtask

  task automatic report_tests();
    logic pending;
    pending = 1'b0;
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < pend[p].size(); i++) begin
        if (pend[p][i].test == open_test) begin
          pending = 1'b1;
        end
      end
    end
    if (open_test != 0 && !pending && cur_test != open_test) begin
      $display("test %0d finished, %0d errors", open_test, test_err[open_test]);
      open_test = cur_test;
    end else if (open_test == 0) begin
      open_test = cur_test;
    end
    done = (open_test == 0) && (cur_test == 0) && pend[0].size() == 0 && pend[1].size() == 0;
  endtask

  // outputs are settled half a period after the edge
  always @(negedge clk) begin
    cyc++;
    if (ready !== !rst_last) begin
      $display("FAILED ready got %h expected %h", ready, !rst_last);
      note_error(open_test);
    end
    rst_last = rst;  // ready follows reset one edge later
    check_port(0);
    check_port(1);
    record_cmds();
    report_tests();
  end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

// File: logic/mem2rw_top.sv
`timescale 1ns/1ps

module mem2rw_top #(
  parameter int NUMADDR    = 8000,
  parameter int NUMVROW    = 1000,  // NUMVBNK * NUMVROW must cover NUMADDR
  parameter int SRAM_DELAY = 2      // at least 1
) (
  input  logic                   clk,
  input  logic                   rst,
  input  mem2rw_pkg::vport_req_t req [2],
  output mem2rw_pkg::vport_rsp_t rsp [2],
  output logic                   ready
);
  import mem2rw_pkg::*;

  bank_req_t        bank_slot  [NUMVBNK][2];
  logic [WIDTH-1:0] bank_rdata [NUMVBNK][2];

  always_ff @(posedge clk) begin
    if (rst) begin
      ready <= 1'b0;
    end else begin
      ready <= 1'b1;  // first cycle after reset release
    end
  end

  mem2rw_core #(
    .NUMADDR    (NUMADDR),
    .NUMVROW    (NUMVROW),
    .SRAM_DELAY (SRAM_DELAY)
  ) u_core (
    .clk        (clk),
    .rst        (rst),
    .ready      (ready),
    .req        (req),
    .rsp        (rsp),
    .bank_slot  (bank_slot),
    .bank_rdata (bank_rdata)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // physical banks, one slot per virtual port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar b = 0; b < NUMVBNK; b++) begin : g_bank
    bank_sram #(
      .NUMVROW    (NUMVROW),
      .SRAM_DELAY (SRAM_DELAY)
    ) u_bank (
      .clk   (clk),
      .rst   (rst),
      .slot  (bank_slot[b]),
      .rdata (bank_rdata[b])
    );
  end

endmodule

// File: logic/mem2rw_core.sv
`timescale 1ns/1ps

module mem2rw_core #(
  parameter int NUMADDR    = 8000,
  parameter int NUMVROW    = 1000,
  parameter int SRAM_DELAY = 2
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         ready,
  input  mem2rw_pkg::vport_req_t       req [2],
  output mem2rw_pkg::vport_rsp_t       rsp [2],
  output mem2rw_pkg::bank_req_t        bank_slot  [mem2rw_pkg::NUMVBNK][2],
  input  logic [mem2rw_pkg::WIDTH-1:0] bank_rdata [mem2rw_pkg::NUMVBNK][2]
);
  import mem2rw_pkg::*;

  typedef struct packed {
    logic               valid;
    logic               fwrd;
    logic [BITVBNK-1:0] bank;
    logic [BITVROW-1:0] row;
    logic [WIDTH-1:0]   data;
  } rd_tag_t;

  logic [1:0]         rd;
  logic [1:0]         wr;
  logic [1:0]         in_range;
  logic [1:0]         hit;
  logic [1:0]         fwd;
  logic [1:0]         move;
  logic [1:0]         flush;
  logic               conflict;
  logic               clear;
  logic [BITVBNK-1:0] bank [2];
  logic [BITVROW-1:0] row  [2];

  // deferred write buffer
  logic               buf_vld;
  logic [BITVBNK-1:0] buf_bank;
  logic [BITVROW-1:0] buf_row;
  logic [WIDTH-1:0]   buf_data;

  // per port access after conflict resolution
  bank_req_t          acc [2];
  logic [BITVBNK-1:0] tgt [2];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address decode and conflict detection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar p = 0; p < 2; p++) begin : g_dec
    vaddr_map #(
      .NUMADDR (NUMADDR),
      .NUMVROW (NUMVROW)
    ) u_map (
      .addr     (req[p].addr),
      .bank     (bank[p]),
      .row      (row[p]),
      .in_range (in_range[p])
    );

    assign rd[p]  = ready & req[p].read;
    assign wr[p]  = ready & req[p].write & in_range[p];  // writes past NUMADDR are dropped
    assign hit[p] = buf_vld & (bank[p] == buf_bank) & (row[p] == buf_row);
    assign fwd[p] = rd[p] & hit[p];
  end

  assign conflict = (rd[0] | wr[0]) & (rd[1] | wr[1]) & (req[0].addr == req[1].addr);

  // port 1 wins when both ports write
  assign move[0]  = conflict & wr[0] & ~wr[1];
  assign move[1]  = conflict & wr[1];
  assign flush[0] = move[0] & buf_vld & ~hit[0];
  assign flush[1] = move[1] & buf_vld & ~hit[1];
  assign clear    = ~conflict & ((wr[0] & hit[0]) | (wr[1] & hit[1]));

  always_ff @(posedge clk) begin
    if (rst) begin
      buf_vld <= 1'b0;
    end else if (move[0] | move[1]) begin
      buf_vld <= 1'b1;
    end else if (clear) begin
      buf_vld <= 1'b0;  // bank now holds the newer value
    end
  end

  always_ff @(posedge clk) begin
    if (move[0]) begin
      buf_bank <= bank[0];
      buf_row  <= row[0];
      buf_data <= req[0].data;
    end else if (move[1]) begin
      buf_bank <= bank[1];
      buf_row  <= row[1];
      buf_data <= req[1].data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bank steering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      acc[p] = '0;
      tgt[p] = bank[p];
      if (rd[p]) begin
        acc[p].read = 1'b1;
        acc[p].row  = row[p];
      end else if (flush[p]) begin
        // own write is held, so the slot drains the older entry
        acc[p].write = 1'b1;
        acc[p].row   = buf_row;
        acc[p].data  = buf_data;
        tgt[p]       = buf_bank;
      end else if (!conflict && wr[p]) begin
        acc[p].write = 1'b1;
        acc[p].row   = row[p];
        acc[p].data  = req[p].data;
      end
    end
  end

  always_comb begin
    for (int b = 0; b < NUMVBNK; b++) begin
      for (int p = 0; p < 2; p++) begin
        bank_slot[b][p] = (tgt[p] == BITVBNK'(b)) ? acc[p] : '0;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read tags and response
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar p = 0; p < 2; p++) begin : g_rsp
    rd_tag_t tag_in;
    rd_tag_t tag_out;

    assign tag_in = '{valid: rd[p], fwrd: fwd[p], bank: bank[p], row: row[p],
                      data: buf_data};

    delay_pipe #(
      .payload_t (rd_tag_t),
      .DEPTH     (SRAM_DELAY)
    ) u_tag_pipe (
      .clk (clk),
      .rst (rst),
      .in  (tag_in),
      .out (tag_out)
    );

    assign rsp[p].valid = tag_out.valid;
    assign rsp[p].fwrd  = tag_out.fwrd;
    assign rsp[p].data  = tag_out.fwrd ? tag_out.data : bank_rdata[tag_out.bank][p];
    assign rsp[p].padr  = {tag_out.bank, tag_out.row};
  end

endmodule

// File: logic/bank_sram.sv
`timescale 1ns/1ps

module bank_sram #(
  parameter int NUMVROW    = 1000,
  parameter int SRAM_DELAY = 2
) (
  input  logic                          clk,
  input  logic                          rst,
  input  mem2rw_pkg::bank_req_t         slot  [2],
  output logic [mem2rw_pkg::WIDTH-1:0]  rdata [2]
);
  import mem2rw_pkg::*;

  logic [WIDTH-1:0] mem [NUMVROW];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the two slots never hit one row with writes in the same cycle
  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (slot[p].write) begin
        mem[slot[p].row] <= slot[p].data;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar p = 0; p < 2; p++) begin : g_slot
    logic [WIDTH-1:0] rd_word;

    // the word is sampled before any write at the same edge lands
    assign rd_word = slot[p].read ? mem[slot[p].row] : '0;

    delay_pipe #(
      .payload_t (logic [WIDTH-1:0]),
      .DEPTH     (SRAM_DELAY)
    ) u_rd_pipe (
      .clk (clk),
      .rst (rst),
      .in  (rd_word),
      .out (rdata[p])
    );
  end

endmodule

// File: logic/delay_pipe.sv
`timescale 1ns/1ps

module delay_pipe #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t in,
  output payload_t out
);

  payload_t stage [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= in;                   // first stage samples at the edge
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign out = stage[DEPTH-1];

endmodule

// File: logic/vaddr_map.sv
`timescale 1ns/1ps

module vaddr_map #(
  parameter int NUMADDR = 8000,
  parameter int NUMVROW = 1000
) (
  input  logic [mem2rw_pkg::BITADDR-1:0] addr,
  output logic [mem2rw_pkg::BITVBNK-1:0] bank,
  output logic [mem2rw_pkg::BITVROW-1:0] row,
  output logic                           in_range
);
  import mem2rw_pkg::*;

  localparam logic [BITADDR-1:0] NROW  = BITADDR'(NUMVROW);
  localparam logic [BITADDR:0]   LIMIT = (BITADDR + 1)'(NUMADDR);  // may equal 2**BITADDR

  logic [BITADDR-1:0] quot;
  logic [BITADDR-1:0] rem;

  // the row count need not be a power of two, so a true divide is used
  assign quot = addr / NROW;
  assign rem  = addr % NROW;

  assign bank     = BITVBNK'(quot);  // out of range addresses wrap here
  assign row      = BITVROW'(rem);
  assign in_range = {1'b0, addr} < LIMIT;

endmodule

// File: logic/mem2rw_pkg.sv
package mem2rw_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fixed widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int WIDTH   = 32;                 // data word
  localparam int BITADDR = 13;                 // virtual address
  localparam int NUMVBNK = 8;
  localparam int BITVBNK = 3;
  localparam int BITVROW = 10;
  localparam int BITPADR = BITVBNK + BITVROW;  // bank index above the row

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // port and bank access records
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic               read;
    logic               write;
    logic [BITADDR-1:0] addr;
    logic [WIDTH-1:0]   data;
  } vport_req_t;

  typedef struct packed {
    logic               valid;
    logic               fwrd;   // data came from the deferred write buffer
    logic [WIDTH-1:0]   data;
    logic [BITPADR-1:0] padr;
  } vport_rsp_t;

  typedef struct packed {
    logic               read;
    logic               write;
    logic [BITVROW-1:0] row;
    logic [WIDTH-1:0]   data;
  } bank_req_t;

endpackage
